/* hdl/pipe_pkg.sv */
package pipe_pkg;

    localparam int xlen       = 32;  // one machine word
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    // field offsets in the instruction word
    localparam int rd_lo     = 0;
    localparam int rj_lo     = 5;
    localparam int rk_lo     = 10;
    localparam int i12_lo    = 10;
    localparam int i16_lo    = 10;
    localparam int i20_lo    = 5;
    localparam int i26_hi_lo = 0;  // offs26[25:16] sits below rj

    // major opcode, inst[31:26]
    localparam logic [5:0] maj_alu   = 6'h00;
    localparam logic [5:0] maj_lu12i = 6'h05;  // with inst[25] clear
    localparam logic [5:0] maj_pcadd = 6'h07;  // with inst[25] clear
    localparam logic [5:0] maj_mem   = 6'h0a;
    localparam logic [5:0] maj_jirl  = 6'h13;
    localparam logic [5:0] maj_b     = 6'h14;
    localparam logic [5:0] maj_bl    = 6'h15;
    localparam logic [5:0] maj_beq   = 6'h16;
    localparam logic [5:0] maj_bne   = 6'h17;
    localparam logic [5:0] maj_blt   = 6'h18;
    localparam logic [5:0] maj_bge   = 6'h19;
    localparam logic [5:0] maj_bltu  = 6'h1a;
    localparam logic [5:0] maj_bgeu  = 6'h1b;

    // inst[31:20] prefix of the reg-reg and shift-imm groups
    localparam logic [11:0] grp_3r    = {maj_alu, 4'h0, 2'h1};
    localparam logic [11:0] grp_shift = {maj_alu, 4'h1, 2'h0};

    // inst[25:22] below maj_alu
    localparam logic [3:0] sub_slti  = 4'h8;
    localparam logic [3:0] sub_sltui = 4'h9;
    localparam logic [3:0] sub_addi  = 4'ha;
    localparam logic [3:0] sub_andi  = 4'hd;
    localparam logic [3:0] sub_ori   = 4'he;
    localparam logic [3:0] sub_xori  = 4'hf;

    // inst[25:22] below maj_mem
    localparam logic [3:0] mem_ld_b  = 4'h0;
    localparam logic [3:0] mem_ld_h  = 4'h1;
    localparam logic [3:0] mem_ld_w  = 4'h2;
    localparam logic [3:0] mem_st_b  = 4'h4;
    localparam logic [3:0] mem_st_h  = 4'h5;
    localparam logic [3:0] mem_st_w  = 4'h6;
    localparam logic [3:0] mem_ld_bu = 4'h8;
    localparam logic [3:0] mem_ld_hu = 4'h9;

    // inst[19:15] inside grp_3r and grp_shift
    localparam logic [4:0] fn_add  = 5'h00;
    localparam logic [4:0] fn_sub  = 5'h02;
    localparam logic [4:0] fn_slt  = 5'h04;
    localparam logic [4:0] fn_sltu = 5'h05;
    localparam logic [4:0] fn_nor  = 5'h08;
    localparam logic [4:0] fn_and  = 5'h09;
    localparam logic [4:0] fn_or   = 5'h0a;
    localparam logic [4:0] fn_xor  = 5'h0b;
    localparam logic [4:0] fn_sll  = 5'h0e;
    localparam logic [4:0] fn_srl  = 5'h0f;
    localparam logic [4:0] fn_sra  = 5'h10;
    localparam logic [4:0] fn_slli = 5'h01;
    localparam logic [4:0] fn_srli = 5'h09;
    localparam logic [4:0] fn_srai = 5'h11;

    localparam int alu_op_w = 12;
    typedef logic [alu_op_w-1:0] alu_op_t;

    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef logic [7:0] mem_ctl_t;  // {mem_we, ld_b, ld_h, ld_w, ld_se, st_b, st_h, st_w}
    typedef logic [5:0] br_cond_t;  // {beq, bne, blt, bltu, bge, bgeu}

    typedef logic [2:0] imm_kind_t;
    localparam imm_kind_t imm_si12 = 3'd0;  // ui5 shares it
    localparam imm_kind_t imm_ui12 = 3'd1;
    localparam imm_kind_t imm_si20 = 3'd2;
    localparam imm_kind_t imm_si16 = 3'd3;
    localparam imm_kind_t imm_si26 = 3'd4;

    typedef logic [1:0] jump_kind_t;
    localparam jump_kind_t jmp_none = 2'd0;
    localparam jump_kind_t jmp_b    = 2'd1;  // b and bl
    localparam jump_kind_t jmp_jirl = 2'd2;

endpackage

/* hdl/id_stage_reg.sv */
`timescale 1ns/1ps

module id_stage_reg (
    input  logic            clk,
    input  logic            resetn,
    input  logic            if_to_id_valid,
    input  pipe_pkg::word_t if_pc,
    input  pipe_pkg::word_t if_inst,
    input  logic            ready_go,
    input  logic            exe_allowin,
    input  logic            br_taken_id,
    input  logic            br_taken_exe,
    output logic            id_valid,
    output pipe_pkg::word_t id_pc,
    output pipe_pkg::word_t inst,
    output logic            id_allowin,
    output logic            id_to_exe_valid
);

    assign id_allowin      = ~id_valid | (ready_go & exe_allowin);
    assign id_to_exe_valid = id_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken_exe) begin
            id_valid <= 1'b0;  // younger than a taken exe branch
        end else if (id_allowin) begin
            // a jump leaving this edge kills the fall-through fetch
            id_valid <= if_to_id_valid & ~br_taken_id;
        end
    end

    // pc and instruction latched on accept
    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_pc <= if_pc;
            inst  <= if_inst;
        end
    end

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  pipe_pkg::word_t     inst,
    output pipe_pkg::reg_addr_t rj,
    output pipe_pkg::reg_addr_t rk_or_rd,
    output logic                need_rj,
    output logic                need_rkd,
    output isa_pkg::alu_op_t    alu_op,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output logic                src2_is_4,
    output isa_pkg::imm_kind_t  imm_kind,
    output logic                res_from_mem,
    output isa_pkg::mem_ctl_t   mem_ctl,
    output logic                rf_we,
    output pipe_pkg::reg_addr_t rf_waddr,
    output isa_pkg::br_cond_t   br_cond,
    output isa_pkg::jump_kind_t jump_kind
);
    import pipe_pkg::*;
    import isa_pkg::*;

    wire [5:0]      op = inst[31:26];
    wire [3:0]      sb = inst[25:22];
    wire [4:0]      fn = inst[19:15];
    wire reg_addr_t rd = inst[rd_lo +: reg_addr_w];
    wire reg_addr_t rk = inst[rk_lo +: reg_addr_w];

    wire is_3r    = (inst[31:20] == grp_3r);
    wire is_shift = (inst[31:20] == grp_shift);
    wire is_alu_i = (op == maj_alu);
    wire is_mem   = (op == maj_mem);

    wire inst_add_w  = is_3r & (fn == fn_add);
    wire inst_sub_w  = is_3r & (fn == fn_sub);
    wire inst_slt    = is_3r & (fn == fn_slt);
    wire inst_sltu   = is_3r & (fn == fn_sltu);
    wire inst_nor    = is_3r & (fn == fn_nor);
    wire inst_and    = is_3r & (fn == fn_and);
    wire inst_or     = is_3r & (fn == fn_or);
    wire inst_xor    = is_3r & (fn == fn_xor);
    wire inst_sll_w  = is_3r & (fn == fn_sll);
    wire inst_srl_w  = is_3r & (fn == fn_srl);
    wire inst_sra_w  = is_3r & (fn == fn_sra);
    wire inst_slli_w = is_shift & (fn == fn_slli);
    wire inst_srli_w = is_shift & (fn == fn_srli);
    wire inst_srai_w = is_shift & (fn == fn_srai);
    wire inst_addi_w = is_alu_i & (sb == sub_addi);
    wire inst_slti   = is_alu_i & (sb == sub_slti);
    wire inst_sltui  = is_alu_i & (sb == sub_sltui);
    wire inst_andi   = is_alu_i & (sb == sub_andi);
    wire inst_ori    = is_alu_i & (sb == sub_ori);
    wire inst_xori   = is_alu_i & (sb == sub_xori);
    wire inst_lu12i  = (op == maj_lu12i) & ~inst[25];
    wire inst_pcadd  = (op == maj_pcadd) & ~inst[25];

    wire inst_ld_b  = is_mem & (sb == mem_ld_b);
    wire inst_ld_h  = is_mem & (sb == mem_ld_h);
    wire inst_ld_w  = is_mem & (sb == mem_ld_w);
    wire inst_ld_bu = is_mem & (sb == mem_ld_bu);
    wire inst_ld_hu = is_mem & (sb == mem_ld_hu);
    wire inst_st_b  = is_mem & (sb == mem_st_b);
    wire inst_st_h  = is_mem & (sb == mem_st_h);
    wire inst_st_w  = is_mem & (sb == mem_st_w);

    wire inst_jirl = (op == maj_jirl);
    wire inst_b    = (op == maj_b);
    wire inst_bl   = (op == maj_bl);
    wire inst_beq  = (op == maj_beq);
    wire inst_bne  = (op == maj_bne);
    wire inst_blt  = (op == maj_blt);
    wire inst_bge  = (op == maj_bge);
    wire inst_bltu = (op == maj_bltu);
    wire inst_bgeu = (op == maj_bgeu);

    // instruction classes
    wire alu_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire alu_ri = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                | inst_sltui | inst_andi | inst_ori | inst_xori;
    wire load   = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire store  = inst_st_b | inst_st_h | inst_st_w;
    wire cbr    = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign rj       = inst[rj_lo +: reg_addr_w];
    assign rk_or_rd = (store | cbr) ? rd : rk;  // store data / compare operand
    assign need_rj  = alu_rr | alu_ri | load | store | cbr | inst_jirl;
    assign need_rkd = alu_rr | store | cbr;

    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | load | store | inst_jirl | inst_bl
                            | inst_pcadd;
    assign alu_op[alu_sub]  = inst_sub_w | inst_beq | inst_bne;
    assign alu_op[alu_slt]  = inst_slt | inst_slti | inst_blt | inst_bge;
    assign alu_op[alu_sltu] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
    assign alu_op[alu_and]  = inst_and | inst_andi;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or | inst_ori;
    assign alu_op[alu_xor]  = inst_xor | inst_xori;
    assign alu_op[alu_sll]  = inst_sll_w | inst_slli_w;
    assign alu_op[alu_srl]  = inst_srl_w | inst_srli_w;
    assign alu_op[alu_sra]  = inst_sra_w | inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i;

    assign src1_is_pc  = inst_jirl | inst_bl | inst_pcadd;
    assign src2_is_imm = alu_ri | inst_lu12i | inst_pcadd | load | store;
    assign src2_is_4   = inst_jirl | inst_bl;  // link value pc+4

    assign imm_kind = (inst_andi | inst_ori | inst_xori) ? imm_ui12
                    : (inst_lu12i | inst_pcadd)          ? imm_si20
                    : (inst_jirl | cbr)                  ? imm_si16
                    : (inst_b | inst_bl)                 ? imm_si26
                    :                                      imm_si12;

    assign res_from_mem = load;
    assign mem_ctl      = {store, inst_ld_b | inst_ld_bu, inst_ld_h | inst_ld_hu, inst_ld_w,
                           inst_ld_b | inst_ld_h, inst_st_b, inst_st_h, inst_st_w};

    assign rf_we    = alu_rr | alu_ri | inst_lu12i | inst_pcadd | load | inst_jirl | inst_bl;
    assign rf_waddr = inst_bl ? reg_addr_t'(1) : rd;  // bl links into r1

    assign br_cond   = {inst_beq, inst_bne, inst_blt, inst_bltu, inst_bge, inst_bgeu};
    assign jump_kind = inst_jirl ? jmp_jirl : (inst_b | inst_bl) ? jmp_b : jmp_none;

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  pipe_pkg::reg_addr_t raddr1,
    input  pipe_pkg::reg_addr_t raddr2,
    input  logic                we,
    input  pipe_pkg::reg_addr_t waddr,
    input  pipe_pkg::word_t     wdata,
    output pipe_pkg::word_t     rdata1,
    output pipe_pkg::word_t     rdata2
);
    import pipe_pkg::*;

    word_t rf [nregs];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // a same-cycle write reaches decode only through wb forwarding
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* hdl/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  logic                id_valid,
    input  pipe_pkg::reg_addr_t rj,
    input  pipe_pkg::reg_addr_t rk_or_rd,
    input  logic                need_rj,
    input  logic                need_rkd,
    input  pipe_pkg::word_t     rf_rdata1,
    input  pipe_pkg::word_t     rf_rdata2,
    input  logic                exe_valid,
    input  logic                exe_rf_we,
    input  pipe_pkg::reg_addr_t exe_rf_waddr,
    input  logic                exe_res_from_mem,
    input  pipe_pkg::word_t     exe_alu_result,
    input  logic                mem_valid,
    input  logic                mem_rf_we,
    input  pipe_pkg::reg_addr_t mem_rf_waddr,
    input  pipe_pkg::word_t     mem_rf_wdata,
    input  logic                wb_valid,
    input  logic                wb_rf_we,
    input  pipe_pkg::reg_addr_t wb_rf_waddr,
    input  pipe_pkg::word_t     wb_rf_wdata,
    output pipe_pkg::word_t     rj_value,
    output pipe_pkg::word_t     rkd_value,
    output logic                ready_go
);
    import pipe_pkg::*;

    // a stage qualifies for a needed, nonzero source it is about to write
    function automatic logic hit(logic v, logic we, reg_addr_t dst, reg_addr_t src, logic need);
        return v & we & need & (src != '0) & (dst == src);
    endfunction

    wire exe_hit1 = hit(exe_valid, exe_rf_we, exe_rf_waddr, rj, need_rj);
    wire exe_hit2 = hit(exe_valid, exe_rf_we, exe_rf_waddr, rk_or_rd, need_rkd);
    wire mem_hit1 = hit(mem_valid, mem_rf_we, mem_rf_waddr, rj, need_rj);
    wire mem_hit2 = hit(mem_valid, mem_rf_we, mem_rf_waddr, rk_or_rd, need_rkd);
    wire wb_hit1  = hit(wb_valid, wb_rf_we, wb_rf_waddr, rj, need_rj);
    wire wb_hit2  = hit(wb_valid, wb_rf_we, wb_rf_waddr, rk_or_rd, need_rkd);

    // youngest producer wins
    assign rj_value  = exe_hit1 ? exe_alu_result
                     : mem_hit1 ? mem_rf_wdata
                     : wb_hit1  ? wb_rf_wdata
                     :            rf_rdata1;
    assign rkd_value = exe_hit2 ? exe_alu_result
                     : mem_hit2 ? mem_rf_wdata
                     : wb_hit2  ? wb_rf_wdata
                     :            rf_rdata2;

    // load data only exists from mem onwards
    assign ready_go = ~(id_valid & exe_res_from_mem & (exe_hit1 | exe_hit2));

endmodule

/* hdl/id_issue.sv */
`timescale 1ns/1ps

module id_issue (
    input  pipe_pkg::word_t     inst,
    input  pipe_pkg::word_t     id_pc,
    input  isa_pkg::imm_kind_t  imm_kind,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  logic                src2_is_4,
    input  isa_pkg::jump_kind_t jump_kind,
    input  pipe_pkg::word_t     rj_value,
    input  pipe_pkg::word_t     rkd_value,
    input  logic                id_valid,
    input  logic                ready_go,
    output pipe_pkg::word_t     alu_src1,
    output pipe_pkg::word_t     alu_src2,
    output logic                br_taken_id,
    output pipe_pkg::word_t     br_target
);
    import pipe_pkg::*;
    import isa_pkg::*;

    wire [11:0] i12 = inst[i12_lo +: 12];
    wire [15:0] i16 = inst[i16_lo +: 16];
    wire [19:0] i20 = inst[i20_lo +: 20];
    wire [25:0] i26 = {inst[i26_hi_lo +: 10], inst[i16_lo +: 16]};
    word_t      imm;

    // branch offsets come out already shifted by two
    always_comb begin
        case (imm_kind)
            imm_ui12: imm = {20'b0, i12};
            imm_si20: imm = {i20, 12'b0};
            imm_si16: imm = {{14{i16[15]}}, i16, 2'b0};
            imm_si26: imm = {{4{i26[25]}}, i26, 2'b0};
            default:  imm = {{20{i12[11]}}, i12};  // ui5 lands in [4:0]
        endcase
    end

    assign alu_src1 = src1_is_pc ? id_pc : rj_value;
    assign alu_src2 = src2_is_4   ? word_t'(4)
                    : src2_is_imm ? imm
                    :               rkd_value;

    assign br_target   = ((jump_kind == jmp_jirl) ? rj_value : id_pc) + imm;
    assign br_taken_id = (jump_kind != jmp_none) & id_valid & ready_go;

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                resetn,
    // fetch
    input  logic                if_to_id_valid,
    input  pipe_pkg::word_t     if_pc,
    input  pipe_pkg::word_t     if_inst,
    output logic                id_allowin,
    output logic                br_taken_id,
    output pipe_pkg::word_t     br_target,
    // execute
    input  logic                exe_allowin,
    input  logic                br_taken_exe,
    output logic                id_to_exe_valid,
    output pipe_pkg::word_t     id_pc,
    output isa_pkg::alu_op_t    alu_op,
    output pipe_pkg::word_t     alu_src1,
    output pipe_pkg::word_t     alu_src2,
    output logic                rf_we,
    output pipe_pkg::reg_addr_t rf_waddr,
    output logic                res_from_mem,
    output isa_pkg::mem_ctl_t   mem_ctl,
    output pipe_pkg::word_t     rkd_value,
    output isa_pkg::br_cond_t   br_cond,
    // forwarding sources with wb doubling as the regfile write port
    input  logic                exe_valid,
    input  logic                exe_rf_we,
    input  pipe_pkg::reg_addr_t exe_rf_waddr,
    input  logic                exe_res_from_mem,
    input  pipe_pkg::word_t     exe_alu_result,
    input  logic                mem_valid,
    input  logic                mem_rf_we,
    input  pipe_pkg::reg_addr_t mem_rf_waddr,
    input  pipe_pkg::word_t     mem_rf_wdata,
    input  logic                wb_valid,
    input  logic                wb_rf_we,
    input  pipe_pkg::reg_addr_t wb_rf_waddr,
    input  pipe_pkg::word_t     wb_rf_wdata
);
    import pipe_pkg::*;
    import isa_pkg::*;

    logic       id_valid;
    logic       id_ready_go;  // low on load-use
    word_t      inst;
    reg_addr_t  rj;
    reg_addr_t  rk_or_rd;
    logic       need_rj;
    logic       need_rkd;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       src2_is_4;
    imm_kind_t  imm_kind;
    jump_kind_t jump_kind;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rj_value;

    id_stage_reg u_stage_reg (
        .clk, .resetn, .if_to_id_valid, .if_pc, .if_inst,
        .ready_go (id_ready_go), .exe_allowin, .br_taken_id, .br_taken_exe,
        .id_valid, .id_pc, .inst, .id_allowin, .id_to_exe_valid
    );

    inst_decoder u_decoder (
        .inst, .rj, .rk_or_rd, .need_rj, .need_rkd,
        .alu_op, .src1_is_pc, .src2_is_imm, .src2_is_4, .imm_kind,
        .res_from_mem, .mem_ctl, .rf_we, .rf_waddr, .br_cond, .jump_kind
    );

    regfile u_regfile (
        .clk,
        .raddr1 (rj),          .raddr2 (rk_or_rd),
        .we     (wb_rf_we),    .waddr  (wb_rf_waddr), .wdata (wb_rf_wdata),
        .rdata1 (rf_rdata1),   .rdata2 (rf_rdata2)
    );

    operand_bypass u_bypass (
        .id_valid, .rj, .rk_or_rd, .need_rj, .need_rkd, .rf_rdata1, .rf_rdata2,
        .exe_valid, .exe_rf_we, .exe_rf_waddr, .exe_res_from_mem, .exe_alu_result,
        .mem_valid, .mem_rf_we, .mem_rf_waddr, .mem_rf_wdata,
        .wb_valid, .wb_rf_we, .wb_rf_waddr, .wb_rf_wdata,
        .rj_value, .rkd_value, .ready_go (id_ready_go)
    );

    id_issue u_issue (
        .inst, .id_pc, .imm_kind, .src1_is_pc, .src2_is_imm, .src2_is_4, .jump_kind,
        .rj_value, .rkd_value, .id_valid, .ready_go (id_ready_go),
        .alu_src1, .alu_src2, .br_taken_id, .br_target
    );

endmodule

/* sim/id_ref_model.svh */
// model state, register file mirror and the instruction in flight
word_t     rf_model [nregs];
int        kind;  // 0-10 reg-reg, 11-13 shift, 14-19 reg-imm, 20 lu12i, 21 pcaddu12i
reg_addr_t f_rd;  // 22-26 loads, 27-29 stores, 30 jirl, 31 b, 32 bl, 33-38 cond branches
reg_addr_t f_rj;
reg_addr_t f_rk;
word_t     f_imm;  // raw random immediate bits
word_t     f_pc;

localparam logic [4:0] fn_tab [14] = '{fn_add, fn_sub, fn_slt, fn_sltu, fn_nor, fn_and,
    fn_or, fn_xor, fn_sll, fn_srl, fn_sra, fn_slli, fn_srli, fn_srai};
localparam logic [3:0] sub_tab [6] = '{sub_addi, sub_slti, sub_sltui, sub_andi, sub_ori,
    sub_xori};
localparam logic [3:0] mem_tab [8] = '{mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu,
    mem_st_b, mem_st_h, mem_st_w};
localparam logic [5:0] br_tab [6] = '{maj_beq, maj_bne, maj_blt, maj_bge, maj_bltu, maj_bgeu};
localparam int br_bit [6] = '{5, 4, 3, 1, 2, 0};  // position in {beq,bne,blt,bltu,bge,bgeu}
localparam int alu_tab [22] = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_nor, alu_and,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_sll, alu_srl, alu_sra, alu_add, alu_slt,
    alu_sltu, alu_and, alu_or, alu_xor, alu_lui, alu_add};

function automatic word_t encode(int k, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk, word_t r);
    if (k < 11) return {grp_3r, fn_tab[k], rk, rj, rd};
    if (k < 14) return {grp_shift, fn_tab[k], rk, rj, rd};  // rk slot is ui5
    if (k < 20) return {maj_alu, sub_tab[k-14], r[11:0], rj, rd};
    if (k < 22) return {(k == 20) ? maj_lu12i : maj_pcadd, 1'b0, r[19:0], rd};
    if (k < 30) return {maj_mem, mem_tab[k-22], r[11:0], rj, rd};
    if (k == 30) return {maj_jirl, r[15:0], rj, rd};
    if (k < 33) return {(k == 31) ? maj_b : maj_bl, r[15:0], r[25:16]};
    return {br_tab[k-33], r[15:0], rj, rd};
endfunction

function automatic word_t imm_of(int k);
    if (k >= 17 && k <= 19) return {20'b0, f_imm[11:0]};
    if (k == 20 || k == 21) return {f_imm[19:0], 12'b0};
    if (k == 31 || k == 32) return {{4{f_imm[25]}}, f_imm[25:0], 2'b0};
    if (k == 30 || k >= 33) return {{14{f_imm[15]}}, f_imm[15:0], 2'b0};
    return {{20{f_imm[11]}}, f_imm[11:0]};
endfunction

// youngest stage first, then the mirrored register file
function automatic word_t fwd(reg_addr_t r);
    if (r == 0) return '0;
    if (exe_valid && exe_rf_we && exe_rf_waddr == r) return exe_alu_result;
    if (mem_valid && mem_rf_we && mem_rf_waddr == r) return mem_rf_wdata;
    if (wb_valid && wb_rf_we && wb_rf_waddr == r) return wb_rf_wdata;
    return rf_model[r];
endfunction

function automatic reg_addr_t rkd_src(int k);
    return ((k >= 27 && k <= 29) || k >= 33) ? f_rd : f_rk;
endfunction

function automatic logic writes_rd(int k);
    return k < 27 || k == 30 || k == 32;
endfunction

function automatic word_t exp_src1();
    return (kind == 21 || kind == 30 || kind == 32) ? f_pc : fwd(f_rj);
endfunction

function automatic word_t exp_src2();
    if (kind == 30 || kind == 32) return 32'd4;
    if (kind < 11) return fwd(f_rk);
    return imm_of(kind);
endfunction

function automatic mem_ctl_t exp_mem_ctl(int k);
    case (k)
        22: return 8'b0100_1000;  // ld.b with sign extension
        23: return 8'b0010_1000;
        24: return 8'b0001_0000;
        25: return 8'b0100_0000;
        26: return 8'b0010_0000;
        27: return 8'b1000_0100;
        28: return 8'b1000_0010;
        29: return 8'b1000_0001;
        default: return 8'b0;
    endcase
endfunction

function automatic br_cond_t exp_br_cond(int k);
    return (k >= 33) ? br_cond_t'(6'b1 << br_bit[k-33]) : '0;
endfunction

function automatic word_t exp_target();
    return ((kind == 30) ? fwd(f_rj) : f_pc) + imm_of(kind);
endfunction

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import pipe_pkg::*;
    import isa_pkg::*;

    localparam int n_alu = 80, n_fwd = 80, n_stall = 20, n_jump = 30, n_mem = 60, n_bp = 20;
    // worst case cycles per instruction in each test plus reset and regfile clear
    localparam int stim_cycles = 2*n_alu + 2*n_fwd + 8*n_stall + 3*n_jump + 3*n_mem
                               + 9*n_bp + 8 + nregs;
    localparam int cycle_limit = 4 * stim_cycles;

    logic clk, resetn, if_to_id_valid, id_allowin, br_taken_id, exe_allowin, br_taken_exe;
    logic id_to_exe_valid, rf_we, res_from_mem;
    logic exe_valid, exe_rf_we, exe_res_from_mem, mem_valid, mem_rf_we, wb_valid, wb_rf_we;
    word_t if_pc, if_inst, br_target, id_pc, alu_src1, alu_src2, rkd_value;
    word_t exe_alu_result, mem_rf_wdata, wb_rf_wdata;
    reg_addr_t rf_waddr, exe_rf_waddr, mem_rf_waddr, wb_rf_waddr;
    alu_op_t alu_op;
    mem_ctl_t mem_ctl;
    br_cond_t br_cond;
    string cur_test;
    int checks, errs, t_checks, t_errs, cycle_count;

    `include "id_ref_model.svh"

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin : watchdog
        wait (cycle_count >= cycle_limit);
        $display("timeout, the run went past %0d cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_val(string field, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s %s expected %h actual %h", cur_test, field, exp, act);
            errs++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            errs++;
        end
    endtask

    // edge, mirror the wb write, then drive point
    task automatic next_cycle();
        @(posedge clk);
        if (wb_rf_we && wb_rf_waddr != 0) rf_model[wb_rf_waddr] = wb_rf_wdata;
        #2;
    endtask

    function automatic reg_addr_t pick_dst(int bias);
        if ($urandom_range(99) < bias) return ($urandom_range(1) == 1) ? f_rj : rkd_src(kind);
        return reg_addr_t'($urandom);
    endfunction

    task automatic set_traffic(int bias);
        exe_valid        = ($urandom_range(1) == 1);
        exe_rf_we        = ($urandom_range(1) == 1);
        exe_rf_waddr     = pick_dst(bias);
        exe_alu_result   = $urandom;
        exe_res_from_mem = 1'b0;
        mem_valid        = ($urandom_range(1) == 1);
        mem_rf_we        = ($urandom_range(1) == 1);
        mem_rf_waddr     = pick_dst(bias);
        mem_rf_wdata     = $urandom;
        wb_valid         = ($urandom_range(1) == 1);
        wb_rf_we         = wb_valid && ($urandom_range(1) == 1);  // never without wb_valid
        wb_rf_waddr      = pick_dst(bias);
        wb_rf_wdata      = $urandom;
    endtask

    task automatic new_inst(int k_lo, int k_hi);
        kind  = $urandom_range(k_hi, k_lo);
        f_rd  = reg_addr_t'($urandom);
        f_rj  = reg_addr_t'($urandom);
        f_rk  = reg_addr_t'($urandom);
        f_imm = $urandom;
        f_pc  = $urandom & ~32'h3;
    endtask

    // holds the instruction on the fetch side up to the accepting edge
    task automatic offer();
        if_to_id_valid = 1'b1;
        if_pc          = f_pc;
        if_inst        = encode(kind, f_rd, f_rj, f_rk, f_imm);
        set_traffic(0);
        @(negedge clk);
        check_true(id_allowin, "stage refused a new instruction");
        next_cycle();
        if_to_id_valid = 1'b0;
        if_inst        = $urandom;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        @(negedge clk);
        while (!id_to_exe_valid && n < 8) begin
            next_cycle();
            @(negedge clk);
            n++;
        end
        check_true(id_to_exe_valid, "instruction never reached execute");
    endtask

    task automatic check_issue();
        check_val("id_pc", f_pc, id_pc);
        if (kind < 22) begin
            check_val("alu_op", 32'(1) << alu_tab[kind], alu_op);
            if (kind != 20) check_val("alu_src1", exp_src1(), alu_src1);
            if (kind >= 11 && kind <= 13) check_val("shift amount", f_rk, alu_src2[4:0]);
            else check_val("alu_src2", exp_src2(), alu_src2);
        end else if (kind < 30 || kind >= 33) begin
            check_val("mem_ctl", exp_mem_ctl(kind), mem_ctl);
            check_val("res_from_mem", kind < 27, res_from_mem);
            check_val("br_cond", exp_br_cond(kind), br_cond);
            if (kind >= 27) check_val("rkd_value", fwd(rkd_src(kind)), rkd_value);
            if (kind < 30) check_val("alu_src1", exp_src1(), alu_src1);
            if (kind < 30) check_val("alu_src2", exp_src2(), alu_src2);
        end else if (kind != 31) begin
            check_val("alu_src1", exp_src1(), alu_src1);
            check_val("alu_src2", exp_src2(), alu_src2);
        end
        check_val("rf_we", writes_rd(kind), rf_we);
        if (writes_rd(kind)) check_val("rf_waddr", (kind == 32) ? 5'd1 : f_rd, rf_waddr);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        t_checks = checks;
        t_errs   = errs;
    endtask

    task automatic end_test();
        $display("%-10s %0d checks, %0d errors", cur_test, checks - t_checks, errs - t_errs);
    endtask

    task automatic run_mix(string name, int k_lo, int k_hi, int n, int bias);
        start_test(name);
        repeat (n) begin
            new_inst(k_lo, k_hi);
            offer();
            set_traffic(bias);
            if (kind >= 30 && kind <= 32) begin
                if_to_id_valid = 1'b1;  // fall-through fetch that has to be dropped
            end
            wait_issue();
            check_issue();
            if (kind >= 30 && kind <= 32) begin
                check_true(br_taken_id, "jump did not raise br_taken_id");
                check_val("br_target", exp_target(), br_target);
                next_cycle();
                if_to_id_valid = 1'b0;
                @(negedge clk);
                check_true(!id_to_exe_valid, "instruction behind a jump reached execute");
            end else begin
                check_true(!br_taken_id, "br_taken_id raised by a non-jump");
            end
            next_cycle();
        end
        end_test();
    endtask

    task automatic run_stall();
        start_test("stall");
        repeat (n_stall) begin
            new_inst(0, 10);
            if (f_rj == 0) f_rj = 5'd7;
            offer();
            set_traffic(50);
            {exe_valid, exe_rf_we, exe_res_from_mem} = 3'b111;  // load into rj
            exe_rf_waddr = f_rj;
            {wb_valid, wb_rf_we} = 2'b00;
            repeat ($urandom_range(4, 1)) begin
                @(negedge clk);
                check_true(!id_to_exe_valid, "issued under a load-use hazard");
                check_true(!id_allowin, "allowin high under a load-use hazard");
                next_cycle();
            end
            exe_res_from_mem = 1'b0;
            wait_issue();
            check_issue();
            next_cycle();
        end
        end_test();
    endtask

    task automatic run_backpressure();
        start_test("bp_flush");
        repeat (n_bp) begin
            new_inst(0, 29);
            offer();
            set_traffic(50);
            {wb_valid, wb_rf_we} = 2'b00;  // keep operands frozen
            exe_allowin = 1'b0;
            wait_issue();
            check_issue();
            repeat ($urandom_range(4, 1)) begin
                next_cycle();
                @(negedge clk);
                check_true(id_to_exe_valid, "held instruction lost its valid");
                check_true(!id_allowin, "allowin high under back-pressure");
                check_issue();  // held payload against the model
            end
            next_cycle();
            br_taken_exe = 1'b1;
            next_cycle();
            br_taken_exe = 1'b0;
            exe_allowin  = 1'b1;
            @(negedge clk);
            check_true(!id_to_exe_valid, "br_taken_exe did not flush the stage");
            next_cycle();
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h0415_2ecc));
        {resetn, if_to_id_valid, br_taken_exe} = 3'b000;
        exe_allowin = 1'b1;
        if_pc       = '0;
        if_inst     = '0;
        set_traffic(0);
        {wb_valid, wb_rf_we} = 2'b00;
        for (int i = 0; i < nregs; i++) rf_model[i] = '0;
        kind = 0;
        {checks, errs, cycle_count} = '0;
        repeat (8) @(posedge clk);
        #2 resetn = 1'b1;
        // clear the register file through the wb port
        for (int i = 1; i < nregs; i++) begin
            {wb_valid, wb_rf_we, wb_rf_waddr, wb_rf_wdata} = {2'b11, reg_addr_t'(i), 32'h0};
            next_cycle();
        end
        run_mix("alu", 0, 21, n_alu, 10);
        run_mix("forward", 0, 29, n_fwd, 80);
        run_stall();
        run_mix("jump", 30, 32, n_jump, 40);
        run_mix("mem_br", 22, 38, n_mem, 40);
        run_backpressure();
        $display("checks: %0d passed, %0d failed", checks - errs, errs);
        if (errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+sim
hdl/pipe_pkg.sv
hdl/isa_pkg.sv
hdl/id_stage_reg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_bypass.sv
hdl/id_issue.sv
hdl/id_stage.sv
sim/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - files:
      - hdl/pipe_pkg.sv
      - hdl/isa_pkg.sv
      - hdl/id_stage_reg.sv
      - hdl/inst_decoder.sv
      - hdl/regfile.sv
      - hdl/operand_bypass.sv
      - hdl/id_issue.sv
      - hdl/id_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_id_stage.sv
